// File: rtl/scan_chain_tester_defs.svh
// --------------------
// sizes shared by the scan-chain test sequencer
// the shift count must hold the value `SCT_CHAIN_LEN
// test_delay, scan_load_delay and the phase counter share one width
// --------------------
`ifndef SCAN_CHAIN_TESTER_DEFS_SVH
`define SCAN_CHAIN_TESTER_DEFS_SVH

// --------------------
// scan chain
// --------------------

// number of flops in the chip scan chain
`define SCT_CHAIN_LEN 16

// shift count width, one bit more than needed for 0..15
// so the terminal value 16 is representable
`define SCT_CNT_W 5

// --------------------
// slot timing
// --------------------

// width of test_delay, scan_load_delay and the phase counter
// a slot is test_delay+1 clk cycles, so up to 64 cycles per slot
`define SCT_DELAY_W 6

`endif

// File: rtl/scan_chain_tester_pkg.sv
// --------------------
// types shared by the sequencer stages
// scan_mode_t values match the chip scan_load pin polarity
// --------------------
package scan_chain_tester_pkg;

  // --------------------
  // sequencer slot states
  // --------------------
  // one state per slot type, in the order the test walks them
  typedef enum logic [2:0] {
    // waiting for start_req
    SEQ_IDLE      = 3'd0,
    // first slot, pins quiet
    SEQ_WAIT      = 3'd1,
    // chip_reset_not pulsed low for one slot
    SEQ_RESET     = 3'd2,
    // trig_out pulsed high for one slot
    SEQ_TRIG      = 3'd3,
    // scan_load_delay slots with the chain in shift mode
    SEQ_LOAD_WAIT = 3'd4,
    // one slot with the comparators loaded in parallel
    SEQ_LOAD      = 3'd5,
    // one slot per chain bit
    SEQ_SHIFT     = 3'd6,
    // start_ack high, result valid
    SEQ_DONE      = 3'd7
  } seq_state_t;

  // --------------------
  // chip scan_load pin
  // --------------------
  // low makes the chain a shift register, high loads the comparators
  typedef enum logic {
    SCAN_MODE_SHIFT = 1'b0,
    SCAN_MODE_LOAD  = 1'b1
  } scan_mode_t;

endpackage

// File: rtl/phase_timer.sv
// --------------------
// slot timer, one tick per test_delay+1 cycles
// restarts from 0 on accept, so the first tick is
// test_delay+1 cycles after the accept edge
// test_delay must be at least 1 and stable during a test
// --------------------
`timescale 1ns/100ps
`include "scan_chain_tester_defs.svh"

module phase_timer (
  input  logic                      clk,
  input  logic                      test_mask_reset_not,
  input  logic                      accept,
  input  logic [`SCT_DELAY_W-1:0]   test_delay,
  output logic                      tick
);

  // phase within the current slot
  logic [`SCT_DELAY_W-1:0] phase_cnt;

  // last cycle of the slot
  assign tick = (phase_cnt == test_delay);

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      phase_cnt <= '0;
    end else if (accept) begin
      // align slot boundaries to the accepted request
      phase_cnt <= '0;
    end else if (tick) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + `SCT_DELAY_W'(1);
    end
  end

  // --------------------
  // checks
  // --------------------
  // a zero delay gives one-cycle slots, which the pin lag
  // and the chip model loopback cannot follow
  a_delay_nonzero : assert property (
    @(posedge clk) disable iff (test_mask_reset_not)
    accept |-> (test_delay != '0)
  );

endmodule

// File: rtl/test_sequencer.sv
// --------------------
// slot FSM for one scan-chain test
// start_req/start_ack is a four-phase handshake, one test in flight
// state moves only on tick, except idle->wait on accept
// and done->idle when start_req drops
// scan_load_delay is sampled at the end of the trigger slot
// and must stay stable through the load-wait slots
// --------------------
`timescale 1ns/100ps
`include "scan_chain_tester_defs.svh"

module test_sequencer (
  input  logic                               clk,
  input  logic                               test_mask_reset_not,
  input  logic                               start_req,
  input  logic                               tick,
  input  logic [`SCT_DELAY_W-1:0]            scan_load_delay,
  input  logic [`SCT_CNT_W-1:0]              shift_cnt,
  output logic                               accept,
  output logic                               shift_en,
  output scan_chain_tester_pkg::seq_state_t  state,
  output logic                               start_ack
);

  // load-wait slots already spent
  logic [`SCT_DELAY_W-1:0] load_wait_cnt;

  // last load-wait slot ends on this tick
  logic load_wait_last;

  // last shift slot ends on this tick
  logic shift_last;

  // --------------------
  // handshake and strobes
  // --------------------
  // request taken only in idle; start_ack is already low there
  assign accept = (state == scan_chain_tester_pkg::SEQ_IDLE) && start_req;

  // one shift per shift slot, at its last cycle
  assign shift_en = tick && (state == scan_chain_tester_pkg::SEQ_SHIFT);

  assign load_wait_last = ((load_wait_cnt + `SCT_DELAY_W'(1)) == scan_load_delay);

  // count is still one short here; it reaches `SCT_CHAIN_LEN
  // on the same edge that leaves the shift phase
  assign shift_last = (shift_cnt == `SCT_CNT_W'(`SCT_CHAIN_LEN - 1));

  // --------------------
  // slot FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      state         <= scan_chain_tester_pkg::SEQ_IDLE;
      start_ack     <= 1'b0;
      load_wait_cnt <= '0;
    end else begin
      case (state)
        scan_chain_tester_pkg::SEQ_IDLE: begin
          if (accept) begin
            state <= scan_chain_tester_pkg::SEQ_WAIT;
          end
        end
        scan_chain_tester_pkg::SEQ_WAIT: begin
          if (tick) begin
            state <= scan_chain_tester_pkg::SEQ_RESET;
          end
        end
        scan_chain_tester_pkg::SEQ_RESET: begin
          if (tick) begin
            state <= scan_chain_tester_pkg::SEQ_TRIG;
          end
        end
        scan_chain_tester_pkg::SEQ_TRIG: begin
          if (tick) begin
            load_wait_cnt <= '0;
            // zero delay skips straight to the parallel load
            if (scan_load_delay == '0) begin
              state <= scan_chain_tester_pkg::SEQ_LOAD;
            end else begin
              state <= scan_chain_tester_pkg::SEQ_LOAD_WAIT;
            end
          end
        end
        scan_chain_tester_pkg::SEQ_LOAD_WAIT: begin
          if (tick) begin
            if (load_wait_last) begin
              state <= scan_chain_tester_pkg::SEQ_LOAD;
            end else begin
              load_wait_cnt <= load_wait_cnt + `SCT_DELAY_W'(1);
            end
          end
        end
        scan_chain_tester_pkg::SEQ_LOAD: begin
          if (tick) begin
            state <= scan_chain_tester_pkg::SEQ_SHIFT;
          end
        end
        scan_chain_tester_pkg::SEQ_SHIFT: begin
          if (tick && shift_last) begin
            state     <= scan_chain_tester_pkg::SEQ_DONE;
            // result settles on this same edge
            start_ack <= 1'b1;
          end
        end
        scan_chain_tester_pkg::SEQ_DONE: begin
          // host holds start_req as long as it needs result
          if (!start_req) begin
            state     <= scan_chain_tester_pkg::SEQ_IDLE;
            start_ack <= 1'b0;
          end
        end
        default: begin
          state     <= scan_chain_tester_pkg::SEQ_IDLE;
          start_ack <= 1'b0;
        end
      endcase
    end
  end

  // --------------------
  // checks
  // --------------------
  a_ack_in_done : assert property (
    @(posedge clk) disable iff (test_mask_reset_not)
    start_ack |-> (state == scan_chain_tester_pkg::SEQ_DONE)
  );

  a_idle_holds : assert property (
    @(posedge clk) disable iff (test_mask_reset_not)
    ((state == scan_chain_tester_pkg::SEQ_IDLE) && !accept)
      |=> (state == scan_chain_tester_pkg::SEQ_IDLE)
  );

endmodule

// File: rtl/scan_shift_register.sv
// --------------------
// test pattern and capture register
// loads pattern on accept, shifts right on shift_en with
// scan_out entering the top bit
// after `SCT_CHAIN_LEN shifts the first captured bit sits in bit 0
// result is undefined until the first accept after reset
// --------------------
`timescale 1ns/100ps
`include "scan_chain_tester_defs.svh"

module scan_shift_register (
  input  logic                        clk,
  input  logic                        test_mask_reset_not,
  input  logic                        accept,
  input  logic [`SCT_CHAIN_LEN-1:0]   pattern,
  input  logic                        shift_en,
  input  logic                        scan_out,
  output logic                        bit0,
  output logic [`SCT_CNT_W-1:0]       shift_cnt,
  output logic [`SCT_CHAIN_LEN-1:0]   result
);

  // pattern going out while captured bits come in from the top
  logic [`SCT_CHAIN_LEN-1:0] shift_reg;

  // --------------------
  // data path
  // --------------------
  // pattern load on accept and right shift with capture
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_reg <= pattern;
    end else if (shift_en) begin
      shift_reg <= {scan_out, shift_reg[`SCT_CHAIN_LEN-1:1]};
    end
  end

  // --------------------
  // shift count
  // --------------------
  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      shift_cnt <= '0;
    end else if (accept) begin
      shift_cnt <= '0;
    end else if (shift_en) begin
      shift_cnt <= shift_cnt + `SCT_CNT_W'(1);
    end
  end

  // next bit for scan_in with the LSB first
  assign bit0 = shift_reg[0];

  // whole register is valid once the count hits the chain length
  assign result = shift_reg;

endmodule

// File: rtl/pin_driver.sv
// --------------------
// registered decode of the slot state onto the chip pins
// pins follow the state one cycle later
// scan_in is held 0 outside the shift slots
// --------------------
`timescale 1ns/100ps

module pin_driver (
  input  logic                               clk,
  input  logic                               test_mask_reset_not,
  input  scan_chain_tester_pkg::seq_state_t  state,
  input  logic                               bit0,
  output logic                               chip_reset_not,
  output logic                               trig_out,
  output logic                               scan_in,
  output scan_chain_tester_pkg::scan_mode_t  scan_load
);

  always_ff @(posedge clk) begin
    if (test_mask_reset_not) begin
      // chip idle: out of reset, no trigger, comparators loaded
      chip_reset_not <= 1'b1;
      trig_out       <= 1'b0;
      scan_in        <= 1'b0;
      scan_load      <= scan_chain_tester_pkg::SCAN_MODE_LOAD;
    end else begin
      // active low reset pulse for one slot
      chip_reset_not <= (state != scan_chain_tester_pkg::SEQ_RESET);

      // trigger pulse for one slot
      trig_out <= (state == scan_chain_tester_pkg::SEQ_TRIG);

      // pattern bit, only while shifting
      if (state == scan_chain_tester_pkg::SEQ_SHIFT) begin
        scan_in <= bit0;
      end else begin
        scan_in <= 1'b0;
      end

      // chain is a shift register during load-wait and shift,
      // parallel load everywhere else including the load slot
      if ((state == scan_chain_tester_pkg::SEQ_LOAD_WAIT) ||
          (state == scan_chain_tester_pkg::SEQ_SHIFT)) begin
        scan_load <= scan_chain_tester_pkg::SCAN_MODE_SHIFT;
      end else begin
        scan_load <= scan_chain_tester_pkg::SCAN_MODE_LOAD;
      end
    end
  end

endmodule

// File: rtl/scan_chain_tester_top.sv
// --------------------
// scan-chain test sequencer top
// pipeline: phase timer, sequencer, scan register, pin driver
// test_delay >= 1 and stable while a test runs
// pattern held with start_req until start_ack
// result valid while start_ack is high
// --------------------
`timescale 1ns/100ps
`include "scan_chain_tester_defs.svh"

module scan_chain_tester_top (
  input  logic                               clk,
  input  logic                               test_mask_reset_not,
  input  logic                               start_req,
  input  logic [`SCT_CHAIN_LEN-1:0]          pattern,
  input  logic [`SCT_DELAY_W-1:0]            test_delay,
  input  logic [`SCT_DELAY_W-1:0]            scan_load_delay,
  input  logic                               scan_out,
  output logic                               start_ack,
  output logic [`SCT_CHAIN_LEN-1:0]          result,
  output logic                               chip_reset_not,
  output logic                               trig_out,
  output logic                               scan_in,
  output scan_chain_tester_pkg::scan_mode_t  scan_load
);

  // --------------------
  // stage links
  // --------------------
  logic                               accept;
  logic                               tick;
  logic                               shift_en;
  logic                               bit0;
  logic [`SCT_CNT_W-1:0]              shift_cnt;
  scan_chain_tester_pkg::seq_state_t  state;

  // slot boundaries
  phase_timer u_phase_timer (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .accept              (accept),
    .test_delay          (test_delay),
    .tick                (tick)
  );

  // slot FSM and handshake
  test_sequencer u_test_sequencer (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .start_req           (start_req),
    .tick                (tick),
    .scan_load_delay     (scan_load_delay),
    .shift_cnt           (shift_cnt),
    .accept              (accept),
    .shift_en            (shift_en),
    .state               (state),
    .start_ack           (start_ack)
  );

  // pattern out, capture in
  scan_shift_register u_scan_shift_register (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .accept              (accept),
    .pattern             (pattern),
    .shift_en            (shift_en),
    .scan_out            (scan_out),
    .bit0                (bit0),
    .shift_cnt           (shift_cnt),
    .result              (result)
  );

  // chip pins
  pin_driver u_pin_driver (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .state               (state),
    .bit0                (bit0),
    .chip_reset_not      (chip_reset_not),
    .trig_out            (trig_out),
    .scan_in             (scan_in),
    .scan_load           (scan_load)
  );

endmodule

// File: verif/tb_scan_chain_tester_tasks.svh
// --------------------
// check, wait and directed test tasks
// included inside the testbench top module
// expected pins come from the slot order and slot length alone
// --------------------
`ifndef TB_SCAN_CHAIN_TESTER_TASKS_SVH
`define TB_SCAN_CHAIN_TESTER_TASKS_SVH

task automatic stop_failed();
  $display("TESTBENCH FAILED");
  $fatal(1, "stopped at first error");
endtask

task automatic check(input string name, input logic [31:0] actual,
                     input logic [31:0] expected);
  if (actual !== expected) begin
    $display("Error: %t %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    stop_failed();
  end
endtask

// start_ack back to 0 once start_req is low, cycles counted
task automatic wait_ack_low(output int cycles);
  cycles = 0;
  while ((start_ack !== 1'b0) && (cycles < 16)) begin
    @(negedge clk);
    cycles++;
  end
  if (start_ack !== 1'b0) begin
    $display("timeout: start_ack stayed high after start_req was lowered");
    stop_failed();
  end
endtask

// --------------------
// one full test
// --------------------
// e counts rising edges from the accept edge (e = 0)
// pins seen after edge e show the slot of edge e-1
task automatic run_test(input logic [`SCT_CHAIN_LEN-1:0] pat, input int delay_val,
                        input int load_val, input int hold_cycles);
  int slot_len;
  int ack_edge;
  int e;
  int n;
  int k;
  bit in_shift;
  bit done;
  logic exp_in;
  scan_chain_tester_pkg::scan_mode_t exp_load;
  logic [`SCT_CHAIN_LEN-1:0] captured;

  slot_len = delay_val + 1;
  // wait, reset, trig, load-wait slots, load, then one slot per bit
  ack_edge = (4 + load_val + `SCT_CHAIN_LEN) * slot_len;
  captured = '0;
  e        = 0;
  done     = 1'b0;
  test_delay      = `SCT_DELAY_W'(delay_val);
  scan_load_delay = `SCT_DELAY_W'(load_val);
  pattern         = pat;
  start_req       = 1'b1;
  while (!done) begin
    @(negedge clk);
    n        = (e == 0) ? -1 : (e - 1) / slot_len;
    in_shift = (n >= 4 + load_val) && (n < 4 + load_val + `SCT_CHAIN_LEN);
    exp_in   = 1'b0;
    exp_load = scan_chain_tester_pkg::SCAN_MODE_LOAD;
    if (in_shift) begin
      // pattern goes out LSB first
      exp_in   = pat[n - 4 - load_val];
      exp_load = scan_chain_tester_pkg::SCAN_MODE_SHIFT;
    end else if ((n >= 3) && (n < 3 + load_val)) begin
      exp_load = scan_chain_tester_pkg::SCAN_MODE_SHIFT;
    end
    check("chip_reset_not", 32'(chip_reset_not), (n == 1) ? 32'd0 : 32'd1);
    check("trig_out", 32'(trig_out), (n == 2) ? 32'd1 : 32'd0);
    check("scan_load", 32'(scan_load), 32'(exp_load));
    check("scan_in", 32'(scan_in), 32'(exp_in));
    // chain bit taken by the DUT at the next edge, if that edge ends a shift slot
    k = (e + 1) / slot_len - (5 + load_val);
    if ((((e + 1) % slot_len) == 0) && (k >= 0) && (k < `SCT_CHAIN_LEN)) begin
      captured[k] = chip_flop;
    end
    if (start_ack === 1'b1) begin
      check("start_ack rise edge", 32'(e), 32'(ack_edge));
      done = 1'b1;
    end else if (e > ack_edge + 4 * slot_len) begin
      $display("timeout: start_ack never rose for pattern 0x%0h", pat);
      stop_failed();
    end
    e++;
  end
  // first captured bit lands in bit 0
  check("result", 32'(result), 32'(captured));
  // host keeps start_req up, acknowledge and result hold
  for (k = 0; k < hold_cycles; k++) begin
    @(negedge clk);
    check("start_ack", 32'(start_ack), 32'd1);
    check("result", 32'(result), 32'(captured));
  end
  start_req = 1'b0;
  wait_ack_low(k);
  check("start_ack fall delay", 32'(k), 32'd1);
endtask

// --------------------
// directed tests
// --------------------
task automatic test_reset_values();
  int i;
  check("start_ack", 32'(start_ack), 32'd0);
  check("chip_reset_not", 32'(chip_reset_not), 32'd1);
  check("trig_out", 32'(trig_out), 32'd0);
  check("scan_in", 32'(scan_in), 32'd0);
  check("scan_load", 32'(scan_load), 32'(scan_chain_tester_pkg::SCAN_MODE_LOAD));
  // no request, no acknowledge
  for (i = 0; i < 4; i++) begin
    @(negedge clk);
    check("start_ack", 32'(start_ack), 32'd0);
  end
endtask

task automatic test_handshake();
  run_test(`SCT_CHAIN_LEN'($random(seed)), 2, 1, 5);
  // second request straight after start_ack fell
  run_test(`SCT_CHAIN_LEN'($random(seed)), 2, 0, 0);
endtask

// 4-cycle slots, reset low then trig high for one slot each
task automatic test_slot_timing();
  run_test(16'hc3a5, 3, 0, 1);
endtask

task automatic test_load_delay();
  run_test(16'h0ff0, 3, 2, 0);
  run_test(16'hf00f, 3, 0, 0);
endtask

task automatic test_shift_data();
  int i;
  logic [`SCT_CHAIN_LEN-1:0] pat;
  for (i = 0; i < 6; i++) begin
    pat = `SCT_CHAIN_LEN'($random(seed));
    // slots of 2 to 5 cycles, load delay 0 to 2
    run_test(pat, 1 + (i % 4), i % 3, i % 2);
  end
endtask

`endif

// File: verif/tb_scan_chain_tester.sv
// --------------------
// testbench for the scan-chain test sequencer
// the chip model loops scan_in back to scan_out through one flop
// all inputs move on the falling edge, outputs are read there too
// the run stops at the first mismatch or timeout
// --------------------
`timescale 1ns/100ps
`include "scan_chain_tester_defs.svh"

module tb_scan_chain_tester;

  // --------------------
  // DUT connections
  // --------------------
  logic                               clk;
  logic                               test_mask_reset_not;
  logic                               start_req;
  logic [`SCT_CHAIN_LEN-1:0]          pattern;
  logic [`SCT_DELAY_W-1:0]            test_delay;
  logic [`SCT_DELAY_W-1:0]            scan_load_delay;
  logic                               scan_out = 1'b0;
  logic                               start_ack;
  logic [`SCT_CHAIN_LEN-1:0]          result;
  logic                               chip_reset_not;
  logic                               trig_out;
  logic                               scan_in;
  scan_chain_tester_pkg::scan_mode_t  scan_load;

  // single flop standing in for the chip scan chain
  logic                               chip_flop = 1'b0;

  // seed for the random patterns
  integer                             seed;

  scan_chain_tester_top i_dut (
    .clk                 (clk),
    .test_mask_reset_not (test_mask_reset_not),
    .start_req           (start_req),
    .pattern             (pattern),
    .test_delay          (test_delay),
    .scan_load_delay     (scan_load_delay),
    .scan_out            (scan_out),
    .start_ack           (start_ack),
    .result              (result),
    .chip_reset_not      (chip_reset_not),
    .trig_out            (trig_out),
    .scan_in             (scan_in),
    .scan_load           (scan_load)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // --------------------
  // chip model
  // --------------------
  // scan_in sampled at each rising edge
  always @(posedge clk) begin
    chip_flop <= scan_in;
  end

  // presented to the DUT on the falling edge
  always @(negedge clk) begin
    scan_out <= chip_flop;
  end

  `include "tb_scan_chain_tester_tasks.svh"

  initial begin
    seed                = 32'h2b0;
    test_mask_reset_not = 1'b1;
    start_req           = 1'b0;
    pattern             = '0;
    test_delay          = `SCT_DELAY_W'(3);
    scan_load_delay     = '0;
    $timeformat(-9, 1, " ns", 10);
    // reset over 5 rising edges, released on a falling edge
    repeat (5) @(posedge clk);
    @(negedge clk);
    test_mask_reset_not = 1'b0;
    test_reset_values();
    test_handshake();
    test_slot_timing();
    test_load_delay();
    test_shift_data();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: scan_chain_tester.f
+incdir+rtl
+incdir+verif
rtl/scan_chain_tester_pkg.sv
rtl/phase_timer.sv
rtl/test_sequencer.sv
rtl/scan_shift_register.sv
rtl/pin_driver.sv
rtl/scan_chain_tester_top.sv
verif/tb_scan_chain_tester.sv

// File: Makefile
# Verilator build and run of the scan-chain tester testbench
# the run passes only if sim.log holds the pass message

TOP := tb_scan_chain_tester

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f scan_chain_tester.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
